//--- bench/input_testdata.txt
// kind j1 j2 btn frames, then expected joy_a joy_b player coin flags
// kind 0 power-up, 1 mapping, 2 single frame, 3 corrupt frame; flags = reset cycles*16 + reboot cycles
0 FFF FFF 3 C 3F 3F 3 3 1000
1 EF5 FFF 3 3 35 3F 2 3 0
1 FFF DEA 3 3 3F 2A 3 1 0
1 FFF FFF 2 3 3F 3F 3 2 0
2 C00 C00 3 4 3F 3F 3 2 0
3 F3C FCF 3 5 3C 0F 3 3 0
1 7FF FFF 3 3 3F 3F 3 3 100
1 7FF FFF 3 6 3F 3F 3 3 0
1 FFF FFF 3 3 3F 3F 3 3 0
1 FFF FFF 1 3 3F 3F 3 3 100
1 FFF FFF 3 3 3F 3F 3 3 0
1 FFF 7FF 3 3 3F 3F 3 3 1
1 FFF 7FF 3 4 3F 3F 3 3 0

//--- bench/tb_arcade_input.sv
/*
  Testbench for arcade_input_top. Plays the external shift register on joy_data.
  Vectors come from bench/input_testdata.txt, read relative to the project root.
  A test's outputs are checked at the joy_load pulse after its last frame.
*/
`timescale 1ns/1ps

module tb_arcade_input;

  import joy_pkg::*;
  import ctrl_pkg::*;

  localparam int FIELDS    = 10;     // Values per data line
  localparam int MAX_TESTS = 32;

  logic       ena_x    = 1'b0;
  logic       pll_lckd = 1'b0;
  logic       joy_data = 1'b1;
  btn_t       btn      = 2'b11;
  logic       joy_load;
  dir_t       joy_a;
  dir_t       joy_b;
  logic [1:0] player;
  logic [1:0] coin;
  logic       game_reset;
  logic       reboot;

  logic [15:0] vec_mem [MAX_TESTS*FIELDS];
  joy_word_t   next_j1    = JOY_RELEASED;   // Words for the next loaded frame
  joy_word_t   next_j2    = JOY_RELEASED;
  btn_t        next_btn   = 2'b11;
  joy_word_t   shift_j1   = JOY_RELEASED;   // Frame being shifted out
  joy_word_t   shift_j2   = JOY_RELEASED;
  int          shift_slot = 0;
  logic [31:0] lcg_state  = 32'd3;
  int          err_cnt    = 0;
  int          cycle_cnt  = 0;
  int          cycle_limit = 1000000;
  int          rst_cycles = 0;
  int          rst_rises  = 0;
  int          reboot_cycles = 0;
  logic        rst_prev   = 1'b0;
  int          last_load  = -1;             // cycle_cnt at the previous load pulse

  always #10 ena_x = ~ena_x;

  arcade_input_top u_arcade_input_top (.*);

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // Serial bit for one counter slot of the frame
  function automatic logic serial_bit(input joy_word_t j1, input joy_word_t j2,
                                      input int slot);
    return SLOT_WORD[slot] ? j2[SLOT_BIT[slot]] : j1[SLOT_BIT[slot]];
  endfunction

  function automatic string kind_label(input int kind);
    case (kind)
      0: return "power-up";
      1: return "mapping";
      2: return "single frame";
      3: return "corrupt frame";
      default: return "unknown kind";
    endcase
  endfunction

  task automatic check_value(input string name, input logic [15:0] exp,
                             input logic [15:0] act);
    if (act !== exp) begin
      $display("ERR %s expected %0h got %0h", name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic verify_outputs(input int t);
    check_value("joy_a", vec_mem[t*FIELDS+5], 16'(joy_a));
    check_value("joy_b", vec_mem[t*FIELDS+6], 16'(joy_b));
    check_value("player", vec_mem[t*FIELDS+7], 16'(player));
    check_value("coin", vec_mem[t*FIELDS+8], 16'(coin));
  endtask

  // Next negedge inside a joy_load low cycle
  // Spacing to the previous pulse must be one frame
  task automatic wait_load();
    @(negedge ena_x);
    while (joy_load !== 1'b0)
      @(negedge ena_x);
    if (last_load >= 0)
      check_value("joy_load period", 16'(FRAME_LEN), 16'(cycle_cnt - last_load));
    last_load = cycle_cnt;
  endtask

  //////////////////////////////////////////////////
  // External shift register model
  //////////////////////////////////////////////////
  always @(posedge ena_x) begin
    if (!joy_load) begin
      shift_j1   = next_j1;
      shift_j2   = next_j2;
      shift_slot = FIRST_BIT_SLOT;
      joy_data <= serial_bit(next_j1, next_j2, FIRST_BIT_SLOT);
      btn      <= next_btn;   // Buttons change with the frame
    end else if (shift_slot >= FIRST_BIT_SLOT && shift_slot < FRAME_LEN - 1) begin
      shift_slot = shift_slot + 1;
      joy_data <= serial_bit(shift_j1, shift_j2, shift_slot);
    end
  end

  //////////////////////////////////////////////////
  // Output monitor and timeout
  //////////////////////////////////////////////////
  always @(negedge ena_x) begin
    if (pll_lckd) begin
      if (game_reset)
        rst_cycles <= rst_cycles + 1;
      if (game_reset && !rst_prev)
        rst_rises <= rst_rises + 1;
      if (reboot)
        reboot_cycles <= reboot_cycles + 1;
      rst_prev <= game_reset;
    end
  end

  always @(posedge ena_x) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("Timeout after %0d cycles, the tests did not finish", cycle_cnt);
      $display("=== FAIL ===");
      $finish;
    end
  end

  initial begin
    int        n_tests;
    int        n_pass;
    int        kind;
    int        frames;
    int        first_check;
    int        err_base;
    int        rst_base;
    int        rise_base;
    int        rbt_base;
    joy_word_t held_j1;
    joy_word_t held_j2;
    btn_t      held_btn;
    for (int i = 0; i < MAX_TESTS * FIELDS; i++)
      vec_mem[i] = 16'hFFFF;            // Kind FFFF ends the list
    $readmemh("bench/input_testdata.txt", vec_mem);
    n_tests = 0;
    cycle_limit = 400;
    while (n_tests < MAX_TESTS && vec_mem[n_tests*FIELDS] != 16'hFFFF) begin
      cycle_limit += int'(vec_mem[n_tests*FIELDS+4]) * FRAME_LEN;
      n_tests++;
    end
    n_pass   = 0;
    held_j1  = JOY_RELEASED;
    held_j2  = JOY_RELEASED;
    held_btn = 2'b11;

    repeat (4) @(posedge ena_x);
    pll_lckd <= 1'b1;

    for (int t = 0; t < n_tests; t++) begin
      kind        = int'(vec_mem[t*FIELDS]);
      frames      = int'(vec_mem[t*FIELDS+4]);
      first_check = (kind == 2) ? 1 : 3;    // Earliest pulse the outputs are settled
      err_base    = err_cnt;
      rst_base    = rst_cycles;
      rise_base   = rst_rises;
      rbt_base    = reboot_cycles;
      if (kind != 2) begin
        held_j1  = vec_mem[t*FIELDS+1][11:0];
        held_j2  = vec_mem[t*FIELDS+2][11:0];
        held_btn = vec_mem[t*FIELDS+3][1:0];
      end
      for (int f = 0; f < frames; f++) begin
        if (f > 0 || t == 0)
          wait_load();
        if (f >= first_check)
          verify_outputs(t);
        next_j1  = held_j1;
        next_j2  = held_j2;
        next_btn = held_btn;
        if (kind == 2 && f == 0) begin
          next_j1  = vec_mem[t*FIELDS+1][11:0];
          next_j2  = vec_mem[t*FIELDS+2][11:0];
          next_btn = vec_mem[t*FIELDS+3][1:0];
        end else if (kind == 3 && f == 2) begin
          lcg_state = lcg_next(lcg_state);
          next_j1   = held_j1 ^ (lcg_state[27:16] | 12'h001);
          lcg_state = lcg_next(lcg_state);
          next_j2   = held_j2 ^ lcg_state[27:16];
        end
      end
      wait_load();
      verify_outputs(t);
      check_value("game_reset cycles", 16'(vec_mem[t*FIELDS+9] >> 4),
                  16'(rst_cycles - rst_base));
      check_value("game_reset pulses", (vec_mem[t*FIELDS+9][15:4] != 12'd0) ? 16'd1 : 16'd0,
                  16'(rst_rises - rise_base));
      check_value("reboot cycles", vec_mem[t*FIELDS+9] & 16'h000F,
                  16'(reboot_cycles - rbt_base));
      if (err_cnt == err_base) begin
        n_pass++;
        $display("test %0d %s passed", t, kind_label(kind));
      end else begin
        $display("test %0d %s failed", t, kind_label(kind));
      end
    end

    if (n_tests == 0) begin
      $display("No test vectors could be read from the data file");
      err_cnt++;
    end
    $display("Tests passed %0d failed %0d", n_pass, n_tests - n_pass);
    if (err_cnt == 0)
      $display("=== PASS ===");
    else
      $display("=== FAIL ===");
    $finish;
  end

endmodule

//--- design/arcade_input_top.sv
/*
  Player-input front end: serial joystick reader, two-frame filters,
  control mapper and reset sequencer, all on ena_x.
  The external shift register must be clocked by ena_x as well.
*/
`timescale 1ns/1ps

module arcade_input_top (
  input  logic           ena_x,
  input  logic           pll_lckd,
  input  logic           joy_data,
  input  ctrl_pkg::btn_t btn,
  output logic           joy_load,
  output ctrl_pkg::dir_t joy_a,
  output ctrl_pkg::dir_t joy_b,
  output logic [1:0]     player,
  output logic [1:0]     coin,
  output logic           game_reset,
  output logic           reboot
);

  import joy_pkg::*;
  import ctrl_pkg::*;

  logic      frame_done;
  joy_pair_t raw_pair;
  joy_pair_t pair_filt;    // Stable joystick words
  btn_t      btn_filt;     // Debounced board buttons
  logic      reset_req;
  logic      reboot_req;

  ////////////////////////////////////////////////////
  // Input side
  ////////////////////////////////////////////////////
  joy_serial_reader u_reader (
    .ena_x      (ena_x),
    .pll_lckd   (pll_lckd),
    .joy_data   (joy_data),
    .joy_load   (joy_load),
    .frame_done (frame_done),
    .raw_pair   (raw_pair)
  );

  frame_filter #(.payload_t(joy_pair_t)) u_pair_filter (
    .ena_x    (ena_x),
    .pll_lckd (pll_lckd),
    .strobe   (frame_done),
    .sample   (raw_pair),
    .filtered (pair_filt)
  );

  // Buttons are sampled at the joystick frame rate
  frame_filter #(.payload_t(btn_t)) u_btn_filter (
    .ena_x    (ena_x),
    .pll_lckd (pll_lckd),
    .strobe   (frame_done),
    .sample   (btn),
    .filtered (btn_filt)
  );

  ////////////////////////////////////////////////////
  // Mapping and reset output
  ////////////////////////////////////////////////////
  control_mapper u_mapper (
    .ena_x      (ena_x),
    .pll_lckd   (pll_lckd),
    .pair       (pair_filt),
    .btn        (btn_filt),
    .joy_a      (joy_a),
    .joy_b      (joy_b),
    .player     (player),
    .coin       (coin),
    .reset_req  (reset_req),
    .reboot_req (reboot_req)
  );

  reset_sequencer u_reset_seq (
    .ena_x      (ena_x),
    .pll_lckd   (pll_lckd),
    .reset_req  (reset_req),
    .reboot_req (reboot_req),
    .game_reset (game_reset),
    .reboot     (reboot)
  );

endmodule

//--- design/control_mapper.sv
/*
  Maps filtered joystick words and board buttons onto game inputs in one
  registered stage. Directions, start and coin stay active low.
  reset_req and reboot_req are active high levels, not pulses.
*/
`timescale 1ns/1ps

module control_mapper (
  input  logic               ena_x,
  input  logic               pll_lckd,
  input  joy_pkg::joy_pair_t pair,
  input  ctrl_pkg::btn_t     btn,
  output ctrl_pkg::dir_t     joy_a,
  output ctrl_pkg::dir_t     joy_b,
  output logic [1:0]         player,
  output logic [1:0]         coin,
  output logic               reset_req,
  output logic               reboot_req
);

  import joy_pkg::*;
  import ctrl_pkg::*;

  always_ff @(posedge ena_x or negedge pll_lckd) begin
    if (!pll_lckd) begin
      joy_a      <= DIR_RELEASED;
      joy_b      <= DIR_RELEASED;
      player     <= 2'b11;
      coin       <= 2'b11;
      reset_req  <= 1'b0;
      reboot_req <= 1'b0;
    end else begin
      joy_a  <= pair.joy1[JOY_DIR_BITS-1:0];
      joy_b  <= pair.joy2[JOY_DIR_BITS-1:0];
      player <= {pair.joy2[JOY_BIT_START], pair.joy1[JOY_BIT_START]};

      // Cabinet coin button doubles as player 1 coin
      coin <= {pair.joy2[JOY_BIT_COIN], pair.joy1[JOY_BIT_COIN] & btn[BTN_COIN]};

      reset_req  <= !pair.joy1[JOY_BIT_RESET] || !btn[BTN_RESET];
      reboot_req <= !pair.joy2[JOY_BIT_RESET];  // Player 2 reset key reboots
    end
  end

endmodule

//--- design/ctrl_pkg.sv
/*
  Arcade control side: board buttons, game input vectors and reset timing.
  All button and direction vectors are active low.
*/
package ctrl_pkg;

  // Board buttons
  localparam int BTN_COIN  = 0;              // Gates coin 1
  localparam int BTN_RESET = 1;              // Game reset

  typedef logic [1:0] btn_t;

  // Directions and fire as seen by the game
  localparam int DIR_BITS = 6;

  typedef logic [DIR_BITS-1:0] dir_t;

  localparam dir_t DIR_RELEASED = '1;

  ////////////////////////////////////////////////////
  // Reset timing, in ena_x cycles
  ////////////////////////////////////////////////////
  localparam int POWERUP_HOLD = 256;         // After pll_lckd rises
  localparam int RESET_HOLD   = 16;          // Per reset request

  // Hold counter must reach POWERUP_HOLD itself
  localparam int HOLD_W = $clog2(POWERUP_HOLD + 1);

endpackage

//--- design/frame_filter.sv
/*
  Two-frame agreement filter. The output follows sample only when two
  consecutive strobed samples are equal, one cycle after the second strobe.
  Reset value of the output and of the stored sample is all ones.
*/
`timescale 1ns/1ps

module frame_filter #(
  parameter type payload_t = logic
) (
  input  logic     ena_x,
  input  logic     pll_lckd,
  input  logic     strobe,
  input  payload_t sample,
  output payload_t filtered
);

  localparam int W = $bits(payload_t);

  payload_t prev_sample;   // Value captured at the previous strobe

  always_ff @(posedge ena_x or negedge pll_lckd) begin
    if (!pll_lckd) begin
      prev_sample <= payload_t'({W{1'b1}});
      filtered    <= payload_t'({W{1'b1}});
    end else if (strobe) begin
      prev_sample <= sample;
      // A single bad frame never matches both neighbours
      if (sample == prev_sample)
        filtered <= sample;
    end
  end

endmodule

//--- design/joy_pkg.sv
/*
  Serial joystick frame layout for two 12-button active-low joysticks.
  The slot tables map each counter value of the 26-clock frame to a word and bit.
  Slots 0 and 1 carry no data, and their table entries are placeholders.
*/
package joy_pkg;

  localparam int JOY_BITS  = 12;             // Buttons per joystick
  localparam int PAIR_BITS = 2 * JOY_BITS;
  localparam int FRAME_LEN = 26;             // Clocks per serial frame
  localparam int CNT_W     = $clog2(FRAME_LEN);
  localparam int FIRST_BIT_SLOT = 2;         // Counter value of first sampled bit

  // Named positions inside one joystick word
  localparam int JOY_DIR_BITS  = 6;          // Up, down, left, right, fire 1, fire 2
  localparam int JOY_BIT_START = 8;
  localparam int JOY_BIT_COIN  = 9;
  localparam int JOY_BIT_RESET = 11;

  typedef logic [JOY_BITS-1:0] joy_word_t;

  // joy1 sits in the low half of the packed pair
  typedef struct packed {
    joy_word_t joy2;
    joy_word_t joy1;
  } joy_pair_t;

  localparam joy_word_t JOY_RELEASED = '1;   // Nothing pressed

  ////////////////////////////////////////////////////
  // Bit slot table, indexed by frame counter value
  ////////////////////////////////////////////////////
  // 0 selects joy1, 1 selects joy2
  localparam bit SLOT_WORD [FRAME_LEN] = '{0, 0,
    0, 0, 0, 0, 0, 0, 0, 0,
    1, 1, 1, 1, 1, 1, 1, 1,
    1, 1, 1, 1,
    0, 0, 0, 0};

  localparam logic [3:0] SLOT_BIT [FRAME_LEN] = '{0, 0,
    8, 6, 5, 4, 3, 2, 1, 0,
    8, 6, 5, 4, 3, 2, 1, 0,
    10, 11, 9, 7,
    10, 11, 9, 7};

endpackage

//--- design/joy_serial_reader.sv
/*
  Reads both joysticks from an external parallel-in/serial-out register
  clocked by ena_x. joy_load is low for one cycle per 26-clock frame.
  Data bits are sampled at counter values 2 to 25, after the load pulse.
  raw_pair only changes at frame end, never in the middle of a frame.
*/
`timescale 1ns/1ps

module joy_serial_reader (
  input  logic               ena_x,
  input  logic               pll_lckd,
  input  logic               joy_data,
  output logic               joy_load,
  output logic               frame_done,
  output joy_pkg::joy_pair_t raw_pair
);

  import joy_pkg::*;

  localparam int LAST_SLOT = FRAME_LEN - 1;
  localparam int POS_W     = $clog2(PAIR_BITS);

  logic [CNT_W-1:0]     frame_cnt;
  logic [PAIR_BITS-1:0] frame_buf;   // Frame being assembled
  logic [PAIR_BITS-1:0] frame_next;
  logic [POS_W-1:0]     bit_pos;     // Target bit inside the packed pair

  ////////////////////////////////////////////////////
  // Frame counter and load strobe
  ////////////////////////////////////////////////////
  always_ff @(posedge ena_x or negedge pll_lckd) begin
    if (!pll_lckd) begin
      frame_cnt <= '0;
      joy_load  <= 1'b1;
    end else begin
      joy_load <= (frame_cnt != '0);  // Low in the cycle after count 0
      if (frame_cnt == CNT_W'(LAST_SLOT))
        frame_cnt <= '0;
      else
        frame_cnt <= frame_cnt + 1'b1;
    end
  end

  ////////////////////////////////////////////////////
  // Bit capture through the slot table
  ////////////////////////////////////////////////////
  assign bit_pos = POS_W'(SLOT_BIT[frame_cnt])
                 + (SLOT_WORD[frame_cnt] ? POS_W'(JOY_BITS) : POS_W'(0));

  always_comb begin
    frame_next = frame_buf;
    case (frame_cnt) inside
      [FIRST_BIT_SLOT:LAST_SLOT]: frame_next[bit_pos] = joy_data;
      default: ;                      // Slots 0 and 1 carry nothing
    endcase
  end

  // Assembly register, one bit written per slot
  always_ff @(posedge ena_x) begin
    frame_buf <= frame_next;
  end

  // Publish the whole frame together with its last bit
  always_ff @(posedge ena_x or negedge pll_lckd) begin
    if (!pll_lckd) begin
      frame_done <= 1'b0;
      raw_pair   <= '{joy2: JOY_RELEASED, joy1: JOY_RELEASED};
    end else begin
      frame_done <= (frame_cnt == CNT_W'(LAST_SLOT));
      if (frame_cnt == CNT_W'(LAST_SLOT))
        raw_pair <= joy_pair_t'(frame_next);
    end
  end

endmodule

//--- design/reset_sequencer.sv
/*
  Game reset and reboot sequencing. game_reset is high for POWERUP_HOLD cycles
  after pll_lckd rises, then for RESET_HOLD cycles after each reset_req edge.
  A request edge during the power-up hold does not shorten it.
  reboot is a single-cycle pulse per reboot_req rising edge.
*/
`timescale 1ns/1ps

module reset_sequencer (
  input  logic ena_x,
  input  logic pll_lckd,
  input  logic reset_req,
  input  logic reboot_req,
  output logic game_reset,
  output logic reboot
);

  import ctrl_pkg::*;

  logic [HOLD_W-1:0] hold_cnt;   // Remaining reset cycles
  logic              reset_req_q;
  logic              reboot_req_q;
  logic              reset_rise;

  assign reset_rise = reset_req && !reset_req_q;

  ////////////////////////////////////////////////////
  // Reset hold counter
  ////////////////////////////////////////////////////
  always_ff @(posedge ena_x or negedge pll_lckd) begin
    if (!pll_lckd) begin
      hold_cnt    <= HOLD_W'(POWERUP_HOLD);
      reset_req_q <= 1'b0;
    end else begin
      reset_req_q <= reset_req;
      if (reset_rise && hold_cnt <= HOLD_W'(RESET_HOLD))
        hold_cnt <= HOLD_W'(RESET_HOLD);   // Restart the stretch
      else if (hold_cnt != '0)
        hold_cnt <= hold_cnt - 1'b1;
    end
  end

  assign game_reset = (hold_cnt != '0);

  ////////////////////////////////////////////////////
  // Reboot pulse
  ////////////////////////////////////////////////////
  always_ff @(posedge ena_x or negedge pll_lckd) begin
    if (!pll_lckd) begin
      reboot_req_q <= 1'b0;
      reboot       <= 1'b0;
    end else begin
      reboot_req_q <= reboot_req;
      reboot       <= reboot_req && !reboot_req_q;  // Held key reboots once
    end
  end

endmodule

//--- run_sim.sh
#!/bin/sh
# Builds and runs the testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_arcade_input -f sim.f -o tb_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/tb_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "=== PASS ==="; then
  exit 0
fi
exit 1

//--- sim.f
design/joy_pkg.sv
design/ctrl_pkg.sv
design/joy_serial_reader.sv
design/frame_filter.sv
design/control_mapper.sv
design/reset_sequencer.sv
design/arcade_input_top.sv
bench/tb_arcade_input.sv
